// ==== source/lsu_pkg.sv ====
package lsu_pkg;

    // Datapath widths
    localparam int DATA_W = 32;
    localparam int ADDR_W = 32;

    // Data RAM holds 2**MEM_AW words
    localparam int MEM_AW = 8;

    // Request FIFO between capture and access unit
    localparam int QUEUE_DEPTH = 4;
    localparam int QUEUE_AW    = 2;

    // Memory opcodes, bit 2 marks a store
    typedef enum logic [3:0] {
        LD_B  = 4'b0000,
        LD_H  = 4'b0001,
        LD_W  = 4'b0010,
        ST_B  = 4'b0100,
        ST_H  = 4'b0101,
        ST_W  = 4'b0110,
        LD_BU = 4'b1000,
        LD_HU = 4'b1001
    } lsu_op_e;

    // Inbound handshake
    typedef enum logic {
        CAP_IDLE     = 1'b0,
        CAP_HOLD_ACK = 1'b1   // in_ack high until in_req drops
    } capture_state_e;

    // Access unit sequencing
    typedef enum logic [1:0] {
        ACC_IDLE      = 2'b00,
        ACC_READ      = 2'b01,  // RAM read in flight
        ACC_RESPOND   = 2'b10,  // out_req high
        ACC_WAIT_DROP = 2'b11   // wait for out_ack low
    } access_state_e;

endpackage

// ==== source/data_sram.sv ====
module data_sram (
    input  logic                       clk,
    input  logic                       en,
    input  logic                       we,
    input  logic [3:0]                 strb,
    input  logic [lsu_pkg::MEM_AW-1:0] word,
    input  logic [lsu_pkg::DATA_W-1:0] wdata,
    output logic [lsu_pkg::DATA_W-1:0] rdata
);

    logic [lsu_pkg::DATA_W-1:0] mem [2**lsu_pkg::MEM_AW];

    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                for (int i = 0; i < 4; i++) begin
                    if (strb[i]) begin
                        mem[word][i*8 +: 8] <= wdata[i*8 +: 8];
                    end
                end
            end
            rdata <= mem[word];   // Old data on a write
        end
    end

endmodule

// ==== source/mem_req_capture.sv ====
module mem_req_capture (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       in_req,
    input  lsu_pkg::lsu_op_e           in_op,
    input  logic [lsu_pkg::ADDR_W-1:0] in_addr,
    input  logic [lsu_pkg::DATA_W-1:0] in_wdata,
    input  logic                       full,
    output logic                       in_ack,
    output logic                       push,
    output lsu_pkg::lsu_op_e           push_op,
    output logic [lsu_pkg::MEM_AW-1:0] push_word,
    output logic [3:0]                 push_strb,
    output logic [lsu_pkg::DATA_W-1:0] push_wdata,
    output logic [1:0]                 push_lane,
    output logic                       push_exc
);

    lsu_pkg::capture_state_e state;
    logic [1:0]              lane;
    logic [3:0]              strb;
    logic                    exc;
    logic                    accept;

    assign lane   = in_addr[1:0];
    assign accept = (state == lsu_pkg::CAP_IDLE) && in_req && !full;
    assign in_ack = (state == lsu_pkg::CAP_HOLD_ACK);

    // Byte lanes touched by the access, zero on misalignment
    always_comb begin
        strb = 4'b0000;
        exc  = 1'b0;
        case (in_op)
            lsu_pkg::LD_B, lsu_pkg::LD_BU, lsu_pkg::ST_B: begin
                strb = 4'b0001 << lane;
            end
            lsu_pkg::LD_H, lsu_pkg::LD_HU, lsu_pkg::ST_H: begin
                if (lane[0]) begin
                    exc = 1'b1;
                end else begin
                    strb = 4'b0011 << lane;
                end
            end
            lsu_pkg::LD_W, lsu_pkg::ST_W: begin
                if (lane != 2'b00) begin
                    exc = 1'b1;
                end else begin
                    strb = 4'b1111;
                end
            end
            default: exc = 1'b1;   // Undefined opcode
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= lsu_pkg::CAP_IDLE;
            push  <= 1'b0;
        end else begin
            push <= accept;
            case (state)
                lsu_pkg::CAP_IDLE: begin
                    if (accept) begin
                        state <= lsu_pkg::CAP_HOLD_ACK;
                    end
                end
                lsu_pkg::CAP_HOLD_ACK: begin
                    if (!in_req) begin
                        state <= lsu_pkg::CAP_IDLE;
                    end
                end
                default: state <= lsu_pkg::CAP_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            push_op    <= in_op;
            push_word  <= in_addr[lsu_pkg::MEM_AW+1:2];  // Upper bits wrap
            push_strb  <= strb;
            push_wdata <= in_wdata << {lane, 3'b000};
            push_lane  <= lane;
            push_exc   <= exc;
        end
    end

    // Queue must have room for every accepted request
    a_no_push_full: assert property (@(posedge clk) disable iff (!arst_n)
        push |-> !full)
        else $error("push while queue full");

    a_ack_needs_req: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(in_ack) |-> $past(in_req))
        else $error("in_ack raised without in_req");

endmodule

// ==== source/mem_req_queue.sv ====
module mem_req_queue (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       push,
    input  lsu_pkg::lsu_op_e           push_op,
    input  logic [lsu_pkg::MEM_AW-1:0] push_word,
    input  logic [3:0]                 push_strb,
    input  logic [lsu_pkg::DATA_W-1:0] push_wdata,
    input  logic [1:0]                 push_lane,
    input  logic                       push_exc,
    input  logic                       pop,
    output logic                       full,
    output logic                       empty,
    output lsu_pkg::lsu_op_e           head_op,
    output logic [lsu_pkg::MEM_AW-1:0] head_word,
    output logic [3:0]                 head_strb,
    output logic [lsu_pkg::DATA_W-1:0] head_wdata,
    output logic [1:0]                 head_lane,
    output logic                       head_exc
);

    lsu_pkg::lsu_op_e           op_mem    [lsu_pkg::QUEUE_DEPTH];
    logic [lsu_pkg::MEM_AW-1:0] word_mem  [lsu_pkg::QUEUE_DEPTH];
    logic [3:0]                 strb_mem  [lsu_pkg::QUEUE_DEPTH];
    logic [lsu_pkg::DATA_W-1:0] wdata_mem [lsu_pkg::QUEUE_DEPTH];
    logic [1:0]                 lane_mem  [lsu_pkg::QUEUE_DEPTH];
    logic                       exc_mem   [lsu_pkg::QUEUE_DEPTH];

    logic [lsu_pkg::QUEUE_AW-1:0] wr_ptr;
    logic [lsu_pkg::QUEUE_AW-1:0] rd_ptr;
    logic [lsu_pkg::QUEUE_AW:0]   count;
    logic                         do_push;
    logic                         do_pop;

    assign full    = (count == (lsu_pkg::QUEUE_AW+1)'(lsu_pkg::QUEUE_DEPTH));
    assign empty   = (count == '0);
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;   // Depth is a power of two
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            op_mem[wr_ptr]    <= push_op;
            word_mem[wr_ptr]  <= push_word;
            strb_mem[wr_ptr]  <= push_strb;
            wdata_mem[wr_ptr] <= push_wdata;
            lane_mem[wr_ptr]  <= push_lane;
            exc_mem[wr_ptr]   <= push_exc;
        end
    end

    assign head_op    = op_mem[rd_ptr];
    assign head_word  = word_mem[rd_ptr];
    assign head_strb  = strb_mem[rd_ptr];
    assign head_wdata = wdata_mem[rd_ptr];
    assign head_lane  = lane_mem[rd_ptr];
    assign head_exc   = exc_mem[rd_ptr];

    a_no_pop_empty: assert property (@(posedge clk) disable iff (!arst_n)
        pop |-> !empty)
        else $error("pop from empty queue");

endmodule

// ==== source/mem_access_unit.sv ====
module mem_access_unit (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       empty,
    input  lsu_pkg::lsu_op_e           head_op,
    input  logic [lsu_pkg::MEM_AW-1:0] head_word,
    input  logic [3:0]                 head_strb,
    input  logic [lsu_pkg::DATA_W-1:0] head_wdata,
    input  logic [1:0]                 head_lane,
    input  logic                       head_exc,
    input  logic [lsu_pkg::DATA_W-1:0] ram_rdata,
    input  logic                       out_ack,
    output logic                       pop,
    output logic                       ram_en,
    output logic                       ram_we,
    output logic [3:0]                 ram_strb,
    output logic [lsu_pkg::MEM_AW-1:0] ram_word,
    output logic [lsu_pkg::DATA_W-1:0] ram_wdata,
    output logic                       out_req,
    output logic [lsu_pkg::DATA_W-1:0] out_rdata,
    output logic                       out_exc
);

    lsu_pkg::access_state_e     state;
    lsu_pkg::lsu_op_e           op_q;
    logic [1:0]                 lane_q;
    logic                       head_store;
    logic [lsu_pkg::DATA_W-1:0] shifted;
    logic [lsu_pkg::DATA_W-1:0] load_data;

    assign pop        = (state == lsu_pkg::ACC_IDLE) && !empty;
    assign head_store = head_op inside {lsu_pkg::ST_B, lsu_pkg::ST_H, lsu_pkg::ST_W};

    // RAM is driven straight from the queue head in the pop cycle
    assign ram_en    = pop && !head_exc;
    assign ram_we    = ram_en && head_store;
    assign ram_strb  = head_strb;
    assign ram_word  = head_word;
    assign ram_wdata = head_wdata;

    // Little-endian lane select, then extend by opcode
    assign shifted = ram_rdata >> {lane_q, 3'b000};

    always_comb begin
        case (op_q)
            lsu_pkg::LD_B:  load_data = {{(lsu_pkg::DATA_W-8){shifted[7]}}, shifted[7:0]};
            lsu_pkg::LD_BU: load_data = {{(lsu_pkg::DATA_W-8){1'b0}}, shifted[7:0]};
            lsu_pkg::LD_H:  load_data = {{(lsu_pkg::DATA_W-16){shifted[15]}}, shifted[15:0]};
            lsu_pkg::LD_HU: load_data = {{(lsu_pkg::DATA_W-16){1'b0}}, shifted[15:0]};
            lsu_pkg::LD_W:  load_data = ram_rdata;
            default:        load_data = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= lsu_pkg::ACC_IDLE;
            out_req <= 1'b0;
        end else begin
            case (state)
                lsu_pkg::ACC_IDLE: begin
                    if (pop) begin
                        if (head_exc || head_store) begin
                            state   <= lsu_pkg::ACC_RESPOND;
                            out_req <= 1'b1;
                        end else begin
                            state <= lsu_pkg::ACC_READ;
                        end
                    end
                end
                lsu_pkg::ACC_READ: begin
                    state   <= lsu_pkg::ACC_RESPOND;
                    out_req <= 1'b1;
                end
                lsu_pkg::ACC_RESPOND: begin
                    if (out_ack) begin
                        state   <= lsu_pkg::ACC_WAIT_DROP;
                        out_req <= 1'b0;
                    end
                end
                lsu_pkg::ACC_WAIT_DROP: begin
                    if (!out_ack) state <= lsu_pkg::ACC_IDLE;
                end
                default: state <= lsu_pkg::ACC_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            op_q      <= head_op;
            lane_q    <= head_lane;
            out_exc   <= head_exc;
            out_rdata <= '0;        // Stores and faults return zero
        end else if (state == lsu_pkg::ACC_READ) begin
            out_rdata <= load_data;
        end
    end

    // Response payload frozen until the receiver acknowledges
    a_resp_stable: assert property (@(posedge clk) disable iff (!arst_n)
        (out_req && !out_ack) |=> ($stable(out_rdata) && $stable(out_exc)))
        else $error("response changed while waiting for out_ack");

endmodule

// ==== source/lsu_top.sv ====
module lsu_top (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       in_req,
    input  lsu_pkg::lsu_op_e           in_op,
    input  logic [lsu_pkg::ADDR_W-1:0] in_addr,
    input  logic [lsu_pkg::DATA_W-1:0] in_wdata,
    input  logic                       out_ack,
    output logic                       in_ack,
    output logic                       out_req,
    output logic [lsu_pkg::DATA_W-1:0] out_rdata,
    output logic                       out_exc
);

    // Capture to queue
    logic                       push;
    lsu_pkg::lsu_op_e           push_op;
    logic [lsu_pkg::MEM_AW-1:0] push_word;
    logic [3:0]                 push_strb;
    logic [lsu_pkg::DATA_W-1:0] push_wdata;
    logic [1:0]                 push_lane;
    logic                       push_exc;
    logic                       full;

    // Queue to access unit
    logic                       pop;
    logic                       empty;
    lsu_pkg::lsu_op_e           head_op;
    logic [lsu_pkg::MEM_AW-1:0] head_word;
    logic [3:0]                 head_strb;
    logic [lsu_pkg::DATA_W-1:0] head_wdata;
    logic [1:0]                 head_lane;
    logic                       head_exc;

    // RAM port
    logic                       ram_en;
    logic                       ram_we;
    logic [3:0]                 ram_strb;
    logic [lsu_pkg::MEM_AW-1:0] ram_word;
    logic [lsu_pkg::DATA_W-1:0] ram_wdata;
    logic [lsu_pkg::DATA_W-1:0] ram_rdata;

    mem_req_capture i_capture (
        .clk, .arst_n, .in_req, .in_op, .in_addr, .in_wdata, .full,
        .in_ack, .push, .push_op, .push_word, .push_strb, .push_wdata,
        .push_lane, .push_exc
    );

    mem_req_queue i_queue (
        .clk, .arst_n, .push, .push_op, .push_word, .push_strb, .push_wdata,
        .push_lane, .push_exc, .pop, .full, .empty, .head_op, .head_word,
        .head_strb, .head_wdata, .head_lane, .head_exc
    );

    mem_access_unit i_access (
        .clk, .arst_n, .empty, .head_op, .head_word, .head_strb, .head_wdata,
        .head_lane, .head_exc, .ram_rdata, .out_ack, .pop, .ram_en, .ram_we,
        .ram_strb, .ram_word, .ram_wdata, .out_req, .out_rdata, .out_exc
    );

    data_sram i_sram (
        .clk   (clk),
        .en    (ram_en),
        .we    (ram_we),
        .strb  (ram_strb),
        .word  (ram_word),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

endmodule

// ==== tests/clock_gen.sv ====
module clock_gen #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;   // Release away from the active edge
    end

endmodule

// ==== tests/lsu_tb.sv ====
module lsu_tb;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 16;
    localparam int ACK_MAX      = 5;
    localparam int N_WORDS      = 2 ** lsu_pkg::MEM_AW;
    localparam int N_SUBWORD    = 64;
    localparam int N_EXT_WORDS  = 16;
    localparam int N_MIS_WORDS  = 8;
    localparam int N_MIX        = 300;
    localparam int TOTAL_OPS    = 2 * N_WORDS + 2 * N_SUBWORD + 13 * N_EXT_WORDS
                                  + 13 * N_MIS_WORDS + N_MIX;
    localparam int WATCHDOG_CYCLES = TOTAL_OPS * 20 + 200;

    logic                       clk;
    logic                       arst_n;
    logic                       in_req;
    lsu_pkg::lsu_op_e           in_op;
    logic [lsu_pkg::ADDR_W-1:0] in_addr;
    logic [lsu_pkg::DATA_W-1:0] in_wdata;
    logic                       in_ack;
    logic                       out_req;
    logic [lsu_pkg::DATA_W-1:0] out_rdata;
    logic                       out_exc;
    logic                       out_ack;

    logic [31:0]      model_mem [N_WORDS];   // Reference memory, little-endian
    lsu_pkg::lsu_op_e exp_op    [$];
    logic [31:0]      exp_addr  [$];
    logic [31:0]      exp_data  [$];
    logic             exp_exc   [$];

    int seed    = 32'hf280;
    int errors  = 0;
    int checks  = 0;
    int tests   = 0;
    int err_mark;
    int chk_mark;

    clock_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) i_clock_gen (
        .clk    (clk),
        .arst_n (arst_n)
    );

    lsu_top i_lsu_top (
        .clk, .arst_n, .in_req, .in_op, .in_addr, .in_wdata, .out_ack,
        .in_ack, .out_req, .out_rdata, .out_exc
    );

    function automatic int rand_below(int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // Random upper bits exercise the address wrap
    function automatic logic [31:0] make_addr(int word, int lane);
        logic [31:0] a;
        a = $random(seed);
        a[lsu_pkg::MEM_AW+1:2] = (lsu_pkg::MEM_AW)'(word);
        a[1:0] = 2'(lane);
        return a;
    endfunction

    function automatic lsu_pkg::lsu_op_e random_op();
        case (rand_below(8))
            0:       return lsu_pkg::LD_B;
            1:       return lsu_pkg::LD_H;
            2:       return lsu_pkg::LD_BU;
            3:       return lsu_pkg::LD_HU;
            4:       return lsu_pkg::ST_B;
            5:       return lsu_pkg::ST_H;
            6:       return lsu_pkg::ST_W;
            default: return lsu_pkg::LD_W;
        endcase
    endfunction

    // Applies one accepted request to the model and queues its response
    task automatic model_access(lsu_pkg::lsu_op_e op, logic [31:0] addr, logic [31:0] wdata);
        int          l;
        int          w;
        logic        misaligned;
        logic [31:0] word_val;
        logic [31:0] rd;
        l = int'(addr[1:0]);
        w = int'(addr[lsu_pkg::MEM_AW+1:2]);
        misaligned = ((op inside {lsu_pkg::LD_H, lsu_pkg::LD_HU, lsu_pkg::ST_H}) && l[0])
                     || ((op inside {lsu_pkg::LD_W, lsu_pkg::ST_W}) && l != 0);
        word_val = model_mem[w];
        rd = '0;
        if (!misaligned) begin
            case (op)
                lsu_pkg::ST_B:  model_mem[w][l*8 +: 8] = wdata[7:0];
                lsu_pkg::ST_H:  model_mem[w][l*8 +: 16] = wdata[15:0];
                lsu_pkg::ST_W:  model_mem[w] = wdata;
                lsu_pkg::LD_B:  rd = {{24{word_val[l*8+7]}}, word_val[l*8 +: 8]};
                lsu_pkg::LD_BU: rd = {24'h0, word_val[l*8 +: 8]};
                lsu_pkg::LD_H:  rd = {{16{word_val[l*8+15]}}, word_val[l*8 +: 16]};
                lsu_pkg::LD_HU: rd = {16'h0, word_val[l*8 +: 16]};
                lsu_pkg::LD_W:  rd = word_val;
                default:        rd = '0;
            endcase
        end
        exp_op.push_back(op);
        exp_addr.push_back(addr);
        exp_data.push_back(rd);
        exp_exc.push_back(misaligned);
    endtask

    // One inbound four-phase transfer
    task automatic send(lsu_pkg::lsu_op_e op, logic [31:0] addr, logic [31:0] wdata);
        @(posedge clk);
        in_op    <= op;
        in_addr  <= addr;
        in_wdata <= wdata;
        in_req   <= 1'b1;
        do begin
            @(negedge clk);
        end while (!in_ack);
        model_access(op, addr, wdata);
        @(posedge clk);
        in_req <= 1'b0;
        do begin
            @(negedge clk);
        end while (in_ack);
    endtask

    task automatic check_response();
        lsu_pkg::lsu_op_e op;
        logic [31:0]      addr;
        logic [31:0]      ed;
        logic             ee;
        checks++;
        assert (exp_data.size() != 0) else begin
            errors++;
            $display("Unexpected response at %0t with no request outstanding", $time);
        end
        if (exp_data.size() != 0) begin
            op   = exp_op.pop_front();
            addr = exp_addr.pop_front();
            ed   = exp_data.pop_front();
            ee   = exp_exc.pop_front();
            assert (out_rdata === ed && out_exc === ee) else begin
                errors++;
                $display("Mismatch at %0t: %s at %h returned %h exc %b, expected %h exc %b",
                         $time, op.name(), addr, out_rdata, out_exc, ed, ee);
            end
        end
    endtask

    task automatic start_test();
        err_mark = errors;
        chk_mark = checks;
    endtask

    task automatic end_test(string name);
        while (exp_data.size() != 0) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
        tests++;
        $display("Test %0s finished: %0d checks, %0d errors",
                 name, checks - chk_mark, errors - err_mark);
    endtask

    // Writeback receiver with random acknowledge delay
    initial begin
        int delay;
        out_ack = 1'b0;
        wait (arst_n === 1'b1);
        forever begin
            @(negedge clk);
            if (out_req) begin
                check_response();
                delay = rand_below(ACK_MAX + 1);
                repeat (delay) @(posedge clk);
                @(posedge clk);
                out_ack <= 1'b1;
                do begin
                    @(negedge clk);
                end while (out_req);
                @(posedge clk);
                out_ack <= 1'b0;
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout after %0d clock periods with %0d responses still missing",
                 WATCHDOG_CYCLES, exp_data.size());
        $display("Verification failed");
        $finish;
    end

    initial begin
        int w;
        in_req   = 1'b0;
        in_op    = lsu_pkg::LD_W;
        in_addr  = '0;
        in_wdata = '0;
        wait (arst_n === 1'b1);

        start_test();
        repeat (10) begin
            @(negedge clk);
            checks++;
            assert (!in_ack && !out_req) else begin
                errors++;
                $display("Mismatch at %0t: in_ack %b out_req %b, expected both low when idle",
                         $time, in_ack, out_req);
            end
        end
        end_test("reset_idle");

        start_test();
        for (int i = 0; i < N_WORDS; i++) begin
            send(lsu_pkg::ST_W, make_addr(i, 0), $random(seed));
        end
        for (int i = 0; i < N_WORDS; i++) begin
            send(lsu_pkg::LD_W, make_addr(i, 0), $random(seed));
        end
        end_test("word_round_trip");

        start_test();
        repeat (N_SUBWORD) begin
            w = rand_below(N_WORDS);
            if (rand_below(2) == 0) begin
                send(lsu_pkg::ST_B, make_addr(w, rand_below(4)), $random(seed));
            end else begin
                send(lsu_pkg::ST_H, make_addr(w, 2 * rand_below(2)), $random(seed));
            end
            send(lsu_pkg::LD_W, make_addr(w, 0), $random(seed));
        end
        end_test("subword_stores");

        start_test();
        repeat (N_EXT_WORDS) begin
            w = rand_below(N_WORDS);
            send(lsu_pkg::ST_W, make_addr(w, 0), $random(seed));
            for (int l = 0; l < 4; l++) begin
                send(lsu_pkg::LD_B, make_addr(w, l), $random(seed));
                send(lsu_pkg::LD_BU, make_addr(w, l), $random(seed));
            end
            for (int l = 0; l < 4; l += 2) begin
                send(lsu_pkg::LD_H, make_addr(w, l), $random(seed));
                send(lsu_pkg::LD_HU, make_addr(w, l), $random(seed));
            end
        end
        end_test("load_extension");

        start_test();
        repeat (N_MIS_WORDS) begin
            w = rand_below(N_WORDS);
            for (int l = 1; l < 4; l++) begin
                send(lsu_pkg::LD_W, make_addr(w, l), $random(seed));
                send(lsu_pkg::ST_W, make_addr(w, l), $random(seed));
                if (l % 2 == 1) begin
                    send(lsu_pkg::LD_H, make_addr(w, l), $random(seed));
                    send(lsu_pkg::LD_HU, make_addr(w, l), $random(seed));
                    send(lsu_pkg::ST_H, make_addr(w, l), $random(seed));
                end
            end
            send(lsu_pkg::LD_W, make_addr(w, 0), $random(seed));   // Word must be untouched
        end
        end_test("misalignment");

        // Requests outpace the receiver so the queue fills up
        start_test();
        repeat (N_MIX) begin
            send(random_op(), make_addr(rand_below(N_WORDS), rand_below(4)), $random(seed));
        end
        end_test("backpressure_order");

        $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
source/lsu_pkg.sv
source/data_sram.sv
source/mem_req_capture.sv
source/mem_req_queue.sv
source/mem_access_unit.sv
source/lsu_top.sv
tests/clock_gen.sv
tests/lsu_tb.sv

// ==== Makefile ====
# Verilator build and run for the load/store unit testbench

VERILATOR ?= verilator
TOP       ?= lsu_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides pass or fail
run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@grep -qx "Verification passed" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }
	@echo "Simulation passed, see $(LOG)"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
